//--- common/ossc_pkg.sv
// ossc_pkg: shared widths, control register bit positions and the OSD palette
`default_nettype none

package ossc_pkg;

    // one color channel
    typedef logic [7:0] color_t;

    // packed pixel, red in the upper byte
    typedef logic [23:0] rgb_t;

    // system control register word
    typedef logic [15:0] sys_ctrl_t;

    // front panel push buttons
    typedef logic [5:0] btn_t;

    // front panel LEDs, blue / green / red from MSB
    typedef logic [2:0] led_t;

    // OSD palette index
    typedef logic [1:0] osd_color_t;

    // system control bit positions
    // bits 3-6 and 8-13 belong to blocks outside this core
    localparam int SYS_POWERON_BIT    = 0;
    localparam int ISL_RESET_N_BIT    = 1;
    localparam int HDMIRX_RESET_N_BIT = 2;
    localparam int CAPTURE_SEL_BIT    = 7;
    localparam int ADAP_LM_BIT        = 14;

    // OSD colors: black, blue, yellow, white
    localparam rgb_t OSD_PALETTE [0:3] = '{
        24'h000000,
        24'h0000ff,
        24'hffff00,
        24'hffffff
    };

    // red LED only while powered off
    localparam led_t LED_POWEROFF = 3'b001;

endpackage

`default_nettype wire

//--- common/video_bus_if.sv
// video_bus_if: pixel, sync and data enable bundle between video pipeline stages
`timescale 1ns/10ps
`default_nettype none

interface video_bus_if;

    import ossc_pkg::*;

    rgb_t rgb;
    logic hsync;
    logic vsync;
    logic de;

    // driving stage
    modport src (
        output rgb,
        output hsync,
        output vsync,
        output de
    );

    // receiving stage
    modport snk (
        input rgb,
        input hsync,
        input vsync,
        input de
    );

endinterface

`default_nettype wire

//--- source/sys_ctrl_regs.sv
// sys_ctrl_regs: CPU-written system control word with readback and field decode
`timescale 1ns/10ps
`default_nettype none

module sys_ctrl_regs (
    input  logic              CLK27_i,
    input  logic              po_reset_n,

    // CPU side
    input  logic              ctrl_wr_i,
    input  ossc_pkg::sys_ctrl_t ctrl_wdata_i,
    output ossc_pkg::sys_ctrl_t ctrl_rdata_o,

    // decoded fields
    output logic              poweron_o,
    output logic              isl_reset_n_o,
    output logic              hdmirx_reset_n_o,
    output logic              capture_sel_o,
    output logic              adap_lm_o
);

    import ossc_pkg::*;

    sys_ctrl_t ctrl_q;

    // all zeros after reset: powered off, both chips held in reset,
    // digitizer selected
    always_ff @(posedge CLK27_i or negedge po_reset_n) begin
        if (!po_reset_n) begin
            ctrl_q <= '0;
        end else if (ctrl_wr_i) begin
            ctrl_q <= ctrl_wdata_i;
        end
    end

    assign ctrl_rdata_o = ctrl_q;

    // the layout is known only here
    assign poweron_o        = ctrl_q[SYS_POWERON_BIT];
    assign isl_reset_n_o    = ctrl_q[ISL_RESET_N_BIT];
    assign hdmirx_reset_n_o = ctrl_q[HDMIRX_RESET_N_BIT];
    assign capture_sel_o    = ctrl_q[CAPTURE_SEL_BIT];
    assign adap_lm_o        = ctrl_q[ADAP_LM_BIT];

endmodule

`default_nettype wire

//--- source/user_panel.sv
// user_panel: button synchronizers, resync pulse stretcher and front panel LED driver
`timescale 1ns/10ps
`default_nettype none

module user_panel #(
    parameter int LED_STRETCH_W = 24
) (
    input  logic           CLK27_i,
    input  logic           po_reset_n,

    input  ossc_pkg::btn_t BTN_i,
    input  logic           resync_strobe_i,

    // state from the control register
    input  logic           poweron_i,
    input  logic           adap_lm_i,
    input  logic           capture_sel_i,

    output ossc_pkg::btn_t btn_o,
    output ossc_pkg::led_t LED_o
);

    import ossc_pkg::*;

    localparam logic [LED_STRETCH_W-1:0] CTR_ONE = 1;

    btn_t btn_sync1_q;

    logic resync_sync1_q;
    logic resync_sync2_q;
    logic resync_prev_q;
    logic resync_rise;
    logic [LED_STRETCH_W-1:0] resync_ctr_q;
    logic resync_active;

    // buttons are active low, so idle is all ones
    always_ff @(posedge CLK27_i or negedge po_reset_n) begin
        if (!po_reset_n) begin
            btn_sync1_q <= '1;
            btn_o       <= '1;
        end else begin
            btn_sync1_q <= BTN_i;
            btn_o       <= btn_sync1_q;
        end
    end

    always_ff @(posedge CLK27_i or negedge po_reset_n) begin
        if (!po_reset_n) begin
            resync_sync1_q <= 1'b0;
            resync_sync2_q <= 1'b0;
            resync_prev_q  <= 1'b0;
        end else begin
            resync_sync1_q <= resync_strobe_i;
            resync_sync2_q <= resync_sync1_q;
            resync_prev_q  <= resync_sync2_q;
        end
    end

    assign resync_rise = resync_sync2_q & ~resync_prev_q;

    // a strobe is only a few cycles long, stretch it so the LED is visible.
    // a new edge restarts the full period
    always_ff @(posedge CLK27_i or negedge po_reset_n) begin
        if (!po_reset_n) begin
            resync_ctr_q <= '0;
        end else if (resync_rise) begin
            resync_ctr_q <= '1;
        end else if (resync_active) begin
            resync_ctr_q <= resync_ctr_q - CTR_ONE;
        end
    end

    assign resync_active = (resync_ctr_q != '0);

    // blue: line multiplier mode, green: digitizer source, red: resync
    assign LED_o = poweron_i ? {adap_lm_i, ~capture_sel_i, resync_active} : LED_POWEROFF;

endmodule

`default_nettype wire

//--- video/video_capture_mux.sv
// video_capture_mux: input registers for both video sources and registered source select
`timescale 1ns/10ps
`default_nettype none

module video_capture_mux (
    input  logic            CLK27_i,
    input  logic            po_reset_n,

    // 0 selects the digitizer, 1 the HDMI receiver
    input  logic            capture_sel_i,

    // RGB digitizer
    input  ossc_pkg::rgb_t  isl_rgb_i,
    input  logic            isl_hsync_i,
    input  logic            isl_vsync_i,
    input  logic            isl_de_i,

    // HDMI receiver
    input  ossc_pkg::rgb_t  hdmirx_rgb_i,
    input  logic            hdmirx_hsync_i,
    input  logic            hdmirx_vsync_i,
    input  logic            hdmirx_de_i,

    video_bus_if.src        cap
);

    import ossc_pkg::*;

    // digitizer, one input stage
    rgb_t isl_rgb_q;
    logic isl_hsync_q;
    logic isl_vsync_q;
    logic isl_de_q;

    // HDMI receiver, two input stages
    rgb_t hdmirx_rgb_q1;
    logic hdmirx_hsync_q1;
    logic hdmirx_vsync_q1;
    logic hdmirx_de_q1;
    rgb_t hdmirx_rgb_q2;
    logic hdmirx_hsync_q2;
    logic hdmirx_vsync_q2;
    logic hdmirx_de_q2;

    always_ff @(posedge CLK27_i or negedge po_reset_n) begin
        if (!po_reset_n) begin
            isl_rgb_q       <= '0;
            isl_hsync_q     <= 1'b0;
            isl_vsync_q     <= 1'b0;
            isl_de_q        <= 1'b0;
            hdmirx_rgb_q1   <= '0;
            hdmirx_hsync_q1 <= 1'b0;
            hdmirx_vsync_q1 <= 1'b0;
            hdmirx_de_q1    <= 1'b0;
            hdmirx_rgb_q2   <= '0;
            hdmirx_hsync_q2 <= 1'b0;
            hdmirx_vsync_q2 <= 1'b0;
            hdmirx_de_q2    <= 1'b0;
        end else begin
            isl_rgb_q       <= isl_rgb_i;
            isl_hsync_q     <= isl_hsync_i;
            isl_vsync_q     <= isl_vsync_i;
            isl_de_q        <= isl_de_i;
            hdmirx_rgb_q1   <= hdmirx_rgb_i;
            hdmirx_hsync_q1 <= hdmirx_hsync_i;
            hdmirx_vsync_q1 <= hdmirx_vsync_i;
            hdmirx_de_q1    <= hdmirx_de_i;
            hdmirx_rgb_q2   <= hdmirx_rgb_q1;
            hdmirx_hsync_q2 <= hdmirx_hsync_q1;
            hdmirx_vsync_q2 <= hdmirx_vsync_q1;
            hdmirx_de_q2    <= hdmirx_de_q1;
        end
    end

    // selection register
    always_ff @(posedge CLK27_i or negedge po_reset_n) begin
        if (!po_reset_n) begin
            cap.rgb   <= '0;
            cap.hsync <= 1'b0;
            cap.vsync <= 1'b0;
            cap.de    <= 1'b0;
        end else begin
            cap.rgb   <= capture_sel_i ? hdmirx_rgb_q2   : isl_rgb_q;
            cap.hsync <= capture_sel_i ? hdmirx_hsync_q2 : isl_hsync_q;
            cap.vsync <= capture_sel_i ? hdmirx_vsync_q2 : isl_vsync_q;
            cap.de    <= capture_sel_i ? hdmirx_de_q2    : isl_de_q;
        end
    end

endmodule

`default_nettype wire

//--- video/osd_overlay.sv
// osd_overlay: OSD palette overlay and transmitter output register with red LSB fix
`timescale 1ns/10ps
`default_nettype none

module osd_overlay #(
    parameter int SI_FIX = 1
) (
    input  logic                 CLK27_i,
    input  logic                 po_reset_n,

    input  logic                 osd_enable_i,
    input  ossc_pkg::osd_color_t osd_color_i,

    video_bus_if.snk             cap,
    video_bus_if.src             out
);

    import ossc_pkg::*;

    // red LSB toggling couples into a neighbouring trace on the board
    localparam rgb_t SI_MASK = (SI_FIX != 0) ? 24'hfe_ffff : 24'hff_ffff;

    rgb_t ovl_rgb_q;
    logic ovl_hsync_q;
    logic ovl_vsync_q;
    logic ovl_de_q;

    // overlay stage, syncs and DE untouched
    always_ff @(posedge CLK27_i or negedge po_reset_n) begin
        if (!po_reset_n) begin
            ovl_rgb_q   <= '0;
            ovl_hsync_q <= 1'b0;
            ovl_vsync_q <= 1'b0;
            ovl_de_q    <= 1'b0;
        end else begin
            ovl_rgb_q   <= osd_enable_i ? OSD_PALETTE[osd_color_i] : cap.rgb;
            ovl_hsync_q <= cap.hsync;
            ovl_vsync_q <= cap.vsync;
            ovl_de_q    <= cap.de;
        end
    end

    // output register toward the transmitter
    always_ff @(posedge CLK27_i or negedge po_reset_n) begin
        if (!po_reset_n) begin
            out.rgb   <= '0;
            out.hsync <= 1'b0;
            out.vsync <= 1'b0;
            out.de    <= 1'b0;
        end else begin
            out.rgb   <= ovl_rgb_q & SI_MASK;
            out.hsync <= ovl_hsync_q;
            out.vsync <= ovl_vsync_q;
            out.de    <= ovl_de_q;
        end
    end

endmodule

`default_nettype wire

//--- source/ossc_pro_core.sv
// ossc_pro_core: scan converter glue core joining control register, front panel and video path
`timescale 1ns/10ps
`default_nettype none

module ossc_pro_core #(
    parameter int LED_STRETCH_W = 24,
    parameter int SI_FIX        = 1
) (
    input  logic                 CLK27_i,
    input  logic                 po_reset_n,

    // CPU control port
    input  logic                 ctrl_wr_i,
    input  ossc_pkg::sys_ctrl_t  ctrl_wdata_i,
    output ossc_pkg::sys_ctrl_t  ctrl_rdata_o,

    // front panel
    input  ossc_pkg::btn_t       BTN_i,
    input  logic                 resync_strobe_i,
    output ossc_pkg::btn_t       btn_o,
    output ossc_pkg::led_t       LED_o,

    // RGB digitizer
    input  ossc_pkg::color_t     ISL_R_i,
    input  ossc_pkg::color_t     ISL_G_i,
    input  ossc_pkg::color_t     ISL_B_i,
    input  logic                 ISL_HSYNC_i,
    input  logic                 ISL_VSYNC_i,
    input  logic                 ISL_DE_i,
    output logic                 ISL_RESET_N_o,

    // HDMI receiver
    input  ossc_pkg::color_t     HDMIRX_R_i,
    input  ossc_pkg::color_t     HDMIRX_G_i,
    input  ossc_pkg::color_t     HDMIRX_B_i,
    input  logic                 HDMIRX_HSYNC_i,
    input  logic                 HDMIRX_VSYNC_i,
    input  logic                 HDMIRX_DE_i,
    output logic                 HDMIRX_RESET_N_o,

    // OSD generator
    input  logic                 osd_enable_i,
    input  ossc_pkg::osd_color_t osd_color_i,

    // HDMI transmitter
    output ossc_pkg::color_t     HDMITX_R_o,
    output ossc_pkg::color_t     HDMITX_G_o,
    output ossc_pkg::color_t     HDMITX_B_o,
    output logic                 HDMITX_HSYNC_o,
    output logic                 HDMITX_VSYNC_o,
    output logic                 HDMITX_DE_o
);

    logic sys_poweron;
    logic capture_sel;
    logic adap_lm;

    video_bus_if cap_bus ();
    video_bus_if out_bus ();

    sys_ctrl_regs u_sys_ctrl_regs (
        .CLK27_i          (CLK27_i),
        .po_reset_n       (po_reset_n),
        .ctrl_wr_i        (ctrl_wr_i),
        .ctrl_wdata_i     (ctrl_wdata_i),
        .ctrl_rdata_o     (ctrl_rdata_o),
        .poweron_o        (sys_poweron),
        .isl_reset_n_o    (ISL_RESET_N_o),
        .hdmirx_reset_n_o (HDMIRX_RESET_N_o),
        .capture_sel_o    (capture_sel),
        .adap_lm_o        (adap_lm)
    );

    user_panel #(
        .LED_STRETCH_W (LED_STRETCH_W)
    ) u_user_panel (
        .CLK27_i         (CLK27_i),
        .po_reset_n      (po_reset_n),
        .BTN_i           (BTN_i),
        .resync_strobe_i (resync_strobe_i),
        .poweron_i       (sys_poweron),
        .adap_lm_i       (adap_lm),
        .capture_sel_i   (capture_sel),
        .btn_o           (btn_o),
        .LED_o           (LED_o)
    );

    video_capture_mux u_video_capture_mux (
        .CLK27_i        (CLK27_i),
        .po_reset_n     (po_reset_n),
        .capture_sel_i  (capture_sel),
        .isl_rgb_i      ({ISL_R_i, ISL_G_i, ISL_B_i}),
        .isl_hsync_i    (ISL_HSYNC_i),
        .isl_vsync_i    (ISL_VSYNC_i),
        .isl_de_i       (ISL_DE_i),
        .hdmirx_rgb_i   ({HDMIRX_R_i, HDMIRX_G_i, HDMIRX_B_i}),
        .hdmirx_hsync_i (HDMIRX_HSYNC_i),
        .hdmirx_vsync_i (HDMIRX_VSYNC_i),
        .hdmirx_de_i    (HDMIRX_DE_i),
        .cap            (cap_bus.src)
    );

    osd_overlay #(
        .SI_FIX (SI_FIX)
    ) u_osd_overlay (
        .CLK27_i      (CLK27_i),
        .po_reset_n   (po_reset_n),
        .osd_enable_i (osd_enable_i),
        .osd_color_i  (osd_color_i),
        .cap          (cap_bus.snk),
        .out          (out_bus.src)
    );

    assign HDMITX_R_o     = out_bus.rgb[23:16];
    assign HDMITX_G_o     = out_bus.rgb[15:8];
    assign HDMITX_B_o     = out_bus.rgb[7:0];
    assign HDMITX_HSYNC_o = out_bus.hsync;
    assign HDMITX_VSYNC_o = out_bus.vsync;
    assign HDMITX_DE_o    = out_bus.de;

endmodule

`default_nettype wire

//--- testbench/ossc_pro_core_assertions.sv
// ossc_pro_core_assertions: bound checks on reset outputs, power-off LED and red LSB fix
`timescale 1ns/10ps
`default_nettype none

module ossc_pro_core_assertions (
    input  logic                CLK27_i,
    input  logic                po_reset_n,
    input  logic                ctrl_wr_i,
    input  ossc_pkg::sys_ctrl_t ctrl_wdata_i,
    input  logic                poweron_i,
    input  ossc_pkg::led_t      led_i,
    input  ossc_pkg::color_t    hdmitx_r_i,
    input  logic                isl_reset_n_i,
    input  logic                hdmirx_reset_n_i
);

    import ossc_pkg::*;

    red_lsb_cleared: assert property (
        @(posedge CLK27_i) disable iff (!po_reset_n) hdmitx_r_i[0] == 1'b0
    ) else $error("red LSB set at the transmitter output");

    led_when_off: assert property (
        @(posedge CLK27_i) disable iff (!po_reset_n) !poweron_i |-> led_i == LED_POWEROFF
    ) else $error("LED pattern wrong while powered off");

    // register takes the word on the strobe edge
    isl_reset_follows: assert property (
        @(posedge CLK27_i) disable iff (!po_reset_n)
        ctrl_wr_i |=> isl_reset_n_i == $past(ctrl_wdata_i[ISL_RESET_N_BIT])
    ) else $error("digitizer reset does not follow the written bit");

    hdmirx_reset_follows: assert property (
        @(posedge CLK27_i) disable iff (!po_reset_n)
        ctrl_wr_i |=> hdmirx_reset_n_i == $past(ctrl_wdata_i[HDMIRX_RESET_N_BIT])
    ) else $error("receiver reset does not follow the written bit");

endmodule

bind ossc_pro_core ossc_pro_core_assertions u_assertions (
    .CLK27_i          (CLK27_i),
    .po_reset_n       (po_reset_n),
    .ctrl_wr_i        (ctrl_wr_i),
    .ctrl_wdata_i     (ctrl_wdata_i),
    .poweron_i        (sys_poweron),
    .led_i            (LED_o),
    .hdmitx_r_i       (HDMITX_R_o),
    .isl_reset_n_i    (ISL_RESET_N_o),
    .hdmirx_reset_n_i (HDMIRX_RESET_N_o)
);

`default_nettype wire

//--- testbench/tb_ossc_pro_core.sv
// tb_ossc_pro_core: testbench for the scan converter glue core, table driven video checks
`timescale 1ns/10ps
`default_nettype none

module tb_ossc_pro_core;

    import ossc_pkg::*;

    localparam int CLK_PERIOD      = 40;
    localparam int LED_W           = 6;
    localparam int STRETCH_CYCLES  = 2**LED_W - 1;
    localparam int NUM_ENTRIES     = 8;
    localparam int ENTRY_CYCLES    = 10;
    localparam int WATCHDOG_CYCLES = NUM_ENTRIES * ENTRY_CYCLES + 100 + 2**LED_W;

    localparam sys_ctrl_t CTRL_WORDS [4] = '{16'h0002, 16'h0004, 16'h0006, 16'hc0f3};

    logic       clk27 = 1'b0;
    logic       po_reset_n;
    logic       ctrl_wr;
    sys_ctrl_t  ctrl_wdata;
    sys_ctrl_t  ctrl_rdata;
    btn_t       btn_in;
    btn_t       btn_sync;
    led_t       led;
    logic       resync_strobe;
    color_t     isl_r, isl_g, isl_b;
    logic       isl_hsync, isl_vsync, isl_de;
    logic       isl_reset_n;
    color_t     hdmirx_r, hdmirx_g, hdmirx_b;
    logic       hdmirx_hsync, hdmirx_vsync, hdmirx_de;
    logic       hdmirx_reset_n;
    logic       osd_enable;
    osd_color_t osd_color;
    color_t     hdmitx_r, hdmitx_g, hdmitx_b;
    logic       hdmitx_hsync, hdmitx_vsync, hdmitx_de;

    integer seed = 32'h612f;

    // video table
    string      entry_name   [NUM_ENTRIES];
    logic       entry_sel    [NUM_ENTRIES];
    rgb_t       entry_isl    [NUM_ENTRIES];
    rgb_t       entry_hdmirx [NUM_ENTRIES];
    logic       entry_hs     [NUM_ENTRIES];
    logic       entry_vs     [NUM_ENTRIES];
    logic       entry_de     [NUM_ENTRIES];
    logic       entry_osd_en [NUM_ENTRIES];
    osd_color_t entry_osd_col[NUM_ENTRIES];

    always #(CLK_PERIOD / 2) clk27 = ~clk27;

    ossc_pro_core #(
        .LED_STRETCH_W (LED_W),
        .SI_FIX        (1)
    ) DUT (
        .CLK27_i          (clk27),
        .po_reset_n       (po_reset_n),
        .ctrl_wr_i        (ctrl_wr),
        .ctrl_wdata_i     (ctrl_wdata),
        .ctrl_rdata_o     (ctrl_rdata),
        .BTN_i            (btn_in),
        .resync_strobe_i  (resync_strobe),
        .btn_o            (btn_sync),
        .LED_o            (led),
        .ISL_R_i          (isl_r),
        .ISL_G_i          (isl_g),
        .ISL_B_i          (isl_b),
        .ISL_HSYNC_i      (isl_hsync),
        .ISL_VSYNC_i      (isl_vsync),
        .ISL_DE_i         (isl_de),
        .ISL_RESET_N_o    (isl_reset_n),
        .HDMIRX_R_i       (hdmirx_r),
        .HDMIRX_G_i       (hdmirx_g),
        .HDMIRX_B_i       (hdmirx_b),
        .HDMIRX_HSYNC_i   (hdmirx_hsync),
        .HDMIRX_VSYNC_i   (hdmirx_vsync),
        .HDMIRX_DE_i      (hdmirx_de),
        .HDMIRX_RESET_N_o (hdmirx_reset_n),
        .osd_enable_i     (osd_enable),
        .osd_color_i      (osd_color),
        .HDMITX_R_o       (hdmitx_r),
        .HDMITX_G_o       (hdmitx_g),
        .HDMITX_B_o       (hdmitx_b),
        .HDMITX_HSYNC_o   (hdmitx_hsync),
        .HDMITX_VSYNC_o   (hdmitx_vsync),
        .HDMITX_DE_o      (hdmitx_de)
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped");
    endtask

    task automatic pixel_check(input string name, input rgb_t expected, input rgb_t actual);
        if (actual !== expected) begin
            fail_run($sformatf("[ERROR] %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic ctrl_check(input string name, input sys_ctrl_t expected,
                              input sys_ctrl_t actual);
        if (actual !== expected) begin
            fail_run($sformatf("[ERROR] %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic btn_check(input string name, input btn_t expected, input btn_t actual);
        if (actual !== expected) begin
            fail_run($sformatf("[ERROR] %s: expected %b, actual %b", name, expected, actual));
        end
    endtask

    task automatic led_check(input string name, input led_t expected, input led_t actual);
        if (actual !== expected) begin
            fail_run($sformatf("[ERROR] %s: expected %b, actual %b", name, expected, actual));
        end
    endtask

    task automatic bit_check(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            fail_run($sformatf("[ERROR] %s: expected %b, actual %b", name, expected, actual));
        end
    endtask

    // black, blue, yellow, white
    function automatic rgb_t palette_color(input osd_color_t idx);
        case (idx)
            2'd0:    return 24'h000000;
            2'd1:    return 24'h0000ff;
            2'd2:    return 24'hffff00;
            default: return 24'hffffff;
        endcase
    endfunction

    function automatic rgb_t clear_red_lsb(input rgb_t pix);
        return {pix[23:17], 1'b0, pix[15:0]};
    endfunction

    task automatic define_entry(input int idx, input string name, input logic sel,
                                input logic hs, input logic vs, input logic de,
                                input logic osd_en, input osd_color_t osd_col);
        logic [31:0] rnd;
        entry_name[idx]    = name;
        entry_sel[idx]     = sel;
        entry_hs[idx]      = hs;
        entry_vs[idx]      = vs;
        entry_de[idx]      = de;
        entry_osd_en[idx]  = osd_en;
        entry_osd_col[idx] = osd_col;
        rnd = $random(seed);
        entry_isl[idx] = rnd[23:0];
        rnd = $random(seed);
        entry_hdmirx[idx] = rnd[23:0];
    endtask

    task automatic write_ctrl(input sys_ctrl_t word);
        @(posedge clk27);
        ctrl_wr    <= 1'b1;
        ctrl_wdata <= word;
        @(posedge clk27);
        ctrl_wr    <= 1'b0;
    endtask

    task automatic drive_video(input rgb_t isl_pix, input rgb_t hdmi_pix,
                               input logic hs, input logic vs, input logic de);
        {isl_r, isl_g, isl_b}          <= isl_pix;
        {hdmirx_r, hdmirx_g, hdmirx_b} <= hdmi_pix;
        isl_hsync    <= hs;
        isl_vsync    <= vs;
        isl_de       <= de;
        hdmirx_hsync <= hs;
        hdmirx_vsync <= vs;
        hdmirx_de    <= de;
    endtask

    task automatic run_entry(input int idx);
        sys_ctrl_t word;
        rgb_t      expected;
        int        latency;
        // power on, both chips out of reset, source from the table
        word = 16'h0007;
        word[CAPTURE_SEL_BIT] = entry_sel[idx];
        latency = entry_sel[idx] ? 5 : 4;
        if (entry_osd_en[idx]) begin
            expected = palette_color(entry_osd_col[idx]);
        end else begin
            expected = entry_sel[idx] ? entry_hdmirx[idx] : entry_isl[idx];
        end
        expected = clear_red_lsb(expected);
        write_ctrl(word);
        drive_video(entry_isl[idx], entry_hdmirx[idx], entry_hs[idx], entry_vs[idx],
                    entry_de[idx]);
        osd_enable <= entry_osd_en[idx];
        osd_color  <= entry_osd_col[idx];
        // inverted filler so a wrong latency shows up
        @(posedge clk27);
        drive_video(~entry_isl[idx], ~entry_hdmirx[idx], ~entry_hs[idx], ~entry_vs[idx],
                    ~entry_de[idx]);
        repeat (latency - 1) @(posedge clk27);
        @(negedge clk27);
        pixel_check(entry_name[idx], expected, {hdmitx_r, hdmitx_g, hdmitx_b});
        bit_check({entry_name[idx], "_hsync"}, entry_hs[idx], hdmitx_hsync);
        bit_check({entry_name[idx], "_vsync"}, entry_vs[idx], hdmitx_vsync);
        bit_check({entry_name[idx], "_de"}, entry_de[idx], hdmitx_de);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        fail_run("watchdog expired before the tests completed");
    end

    initial begin
        logic [31:0] rnd;
        int          rise_wait;
        int          high_cycles;

        po_reset_n    = 1'b0;
        ctrl_wr       = 1'b0;
        ctrl_wdata    = '0;
        btn_in        = '1;
        resync_strobe = 1'b0;
        drive_video(24'h0, 24'h0, 1'b0, 1'b0, 1'b0);
        osd_enable    = 1'b0;
        osd_color     = '0;

        repeat (8) @(posedge clk27);
        po_reset_n <= 1'b1;
        @(negedge clk27);
        ctrl_check("reset_ctrl", 16'h0000, ctrl_rdata);
        bit_check("reset_isl_reset_n", 1'b0, isl_reset_n);
        bit_check("reset_hdmirx_reset_n", 1'b0, hdmirx_reset_n);
        pixel_check("reset_hdmitx", 24'h000000, {hdmitx_r, hdmitx_g, hdmitx_b});
        bit_check("reset_hdmitx_hsync", 1'b0, hdmitx_hsync);
        bit_check("reset_hdmitx_vsync", 1'b0, hdmitx_vsync);
        bit_check("reset_hdmitx_de", 1'b0, hdmitx_de);
        btn_check("reset_btn", 6'b111111, btn_sync);
        led_check("reset_led", 3'b001, led);

        foreach (CTRL_WORDS[i]) begin
            write_ctrl(CTRL_WORDS[i]);
            @(negedge clk27);
            ctrl_check("ctrl_readback", CTRL_WORDS[i], ctrl_rdata);
            bit_check("isl_reset_n", CTRL_WORDS[i][ISL_RESET_N_BIT], isl_reset_n);
            bit_check("hdmirx_reset_n", CTRL_WORDS[i][HDMIRX_RESET_N_BIT], hdmirx_reset_n);
        end

        define_entry(0, "isl_plain_a",       1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 2'd0);
        define_entry(1, "isl_plain_b",       1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 2'd0);
        define_entry(2, "hdmirx_plain_a",    1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 2'd0);
        define_entry(3, "hdmirx_plain_b",    1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 2'd0);
        define_entry(4, "isl_osd_black",     1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 2'd0);
        define_entry(5, "isl_osd_blue",      1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 2'd1);
        define_entry(6, "hdmirx_osd_yellow", 1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 2'd2);
        define_entry(7, "hdmirx_osd_white",  1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 2'd3);
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            run_entry(i);
        end

        for (int i = 0; i < 8; i++) begin
            rnd = $random(seed);
            @(posedge clk27);
            btn_in <= rnd[5:0];
            repeat (2) @(posedge clk27);
            @(negedge clk27);
            btn_check("btn_sync", rnd[5:0], btn_sync);
        end

        // power on, receiver source, no line multiplier
        write_ctrl(16'h0087);
        @(negedge clk27);
        led_check("led_hdmirx_src", 3'b000, led);

        // power on, line multiplier mode, digitizer source
        write_ctrl(16'h4007);
        @(negedge clk27);
        led_check("led_idle", 3'b110, led);
        @(posedge clk27);
        resync_strobe <= 1'b1;
        rise_wait = 0;
        @(negedge clk27);
        while (!led[0] && rise_wait < 3) begin
            rise_wait++;
            @(negedge clk27);
        end
        if (!led[0]) begin
            fail_run("resync LED did not light within 3 cycles of the strobe");
        end
        led_check("led_resync", 3'b111, led);
        high_cycles = 0;
        while (led[0] && high_cycles < 2**LED_W + 8) begin
            high_cycles++;
            @(negedge clk27);
        end
        if (high_cycles < STRETCH_CYCLES - 1 || high_cycles > STRETCH_CYCLES + 1) begin
            fail_run($sformatf("[ERROR] resync_stretch: expected %0d, actual %0d",
                               STRETCH_CYCLES, high_cycles));
        end
        @(posedge clk27);
        resync_strobe <= 1'b0;
        write_ctrl(16'h4006);
        @(negedge clk27);
        led_check("led_poweroff", 3'b001, led);

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
common/ossc_pkg.sv
common/video_bus_if.sv
source/sys_ctrl_regs.sv
source/user_panel.sv
video/video_capture_mux.sv
video/osd_overlay.sv
source/ossc_pro_core.sv
testbench/ossc_pro_core_assertions.sv
testbench/tb_ossc_pro_core.sv

//--- Makefile
TOP := tb_ossc_pro_core

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module $(TOP) -f verilog.f -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
